// File: rtl/wiener_stats_pkg.sv
// Block size, counter widths, sample/sum/variance types and controller states
`default_nettype none

package wiener_stats_pkg;

	// Sample format
	localparam int SAMPLE_W = 8;

	// Block geometry, BLOCK_SAMPLES must stay a power of two
	localparam int BLOCK_SAMPLES = 16;
	localparam int BLOCK_LOG2 = $clog2(BLOCK_SAMPLES);

	localparam int COUNT_W = BLOCK_LOG2 + 1; // Counts 0 .. BLOCK_SAMPLES
	localparam int BLOCKS_W = 16; // Blocks per frame

	typedef logic [SAMPLE_W-1:0] sample_t;

	// Sum of one block of samples
	typedef logic [SAMPLE_W+BLOCK_LOG2-1:0] sum_t;

	// Squared deviation sum and floored variance
	typedef logic [2*SAMPLE_W+BLOCK_LOG2-1:0] var_t;

	// Block controller states
	typedef enum logic [1:0] {
		IDLE,
		READ_BLOCK,
		WAIT_FOR_MEAN,
		EMPTY_BUFFER
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: rtl/block_stats_ctrl.sv
// Frame and block sequencing FSM driving shift enables, mean load and variance start
`timescale 1ns/100ps
`default_nettype none

module block_stats_ctrl (
	input  wire                                   clk,
	input  wire                                   rst_n,
	input  wire                                   start_of_frame,
	input  wire [wiener_stats_pkg::BLOCKS_W-1:0]  blocks_per_frame,
	input  wire                                   mean_ready,
	input  wire                                   var_ready,
	output logic                                  sample_take,
	output logic                                  shift_en_2,
	output logic                                  shift_reg_clr,
	output logic                                  shift_en_mean,
	output logic                                  var_start,
	output logic                                  frame_done,
	output logic                                  busy
);
	import wiener_stats_pkg::*;

	localparam logic [COUNT_W-1:0] LAST_SAMPLE = COUNT_W'(BLOCK_SAMPLES - 1);
	localparam logic [COUNT_W-1:0] FLUSH_END = COUNT_W'(BLOCK_SAMPLES);

	ctrl_state_t state;
	ctrl_state_t next_state;
	logic [COUNT_W-1:0] sample_cnt;
	logic [BLOCKS_W-1:0] block_cnt;
	logic [BLOCKS_W-1:0] block_cnt_next;
	logic last_block;
	logic var_seen; // Last block's variance has come back
	logic flush_exit;

	assign block_cnt_next = block_cnt + 1'b1;
	assign last_block = (block_cnt_next == blocks_per_frame);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (start_of_frame) begin
					next_state = READ_BLOCK;
				end
			end
			READ_BLOCK: begin
				if (sample_cnt == LAST_SAMPLE) begin
					next_state = WAIT_FOR_MEAN;
				end
			end
			WAIT_FOR_MEAN: begin
				if (mean_ready) begin
					next_state = last_block ? EMPTY_BUFFER : READ_BLOCK;
				end
			end
			EMPTY_BUFFER: begin
				// Flush done and final variance seen
				if (sample_cnt == FLUSH_END && (var_seen || var_ready)) begin
					next_state = IDLE;
				end
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	assign sample_take = (state == READ_BLOCK);
	assign shift_en_2 = (state == READ_BLOCK) ||
		(state == EMPTY_BUFFER && sample_cnt != FLUSH_END);
	assign shift_reg_clr = (state == IDLE);
	assign shift_en_mean = (state == WAIT_FOR_MEAN) && mean_ready;
	assign busy = (state != IDLE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sample_cnt <= '0;
			block_cnt <= '0;
			var_seen <= 1'b0;
			var_start <= 1'b0;
			flush_exit <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			var_start <= shift_en_mean; // One cycle after the mean load
			flush_exit <= (state == EMPTY_BUFFER) && (next_state == IDLE);
			frame_done <= flush_exit;
			case (state)
				IDLE: begin
					sample_cnt <= '0;
					block_cnt <= '0;
					var_seen <= 1'b0;
				end
				READ_BLOCK: begin
					sample_cnt <= (sample_cnt == LAST_SAMPLE) ? '0 : sample_cnt + 1'b1;
				end
				WAIT_FOR_MEAN: begin
					var_seen <= 1'b0;
					if (mean_ready) begin
						block_cnt <= block_cnt_next;
					end
				end
				EMPTY_BUFFER: begin
					if (sample_cnt != FLUSH_END) begin
						sample_cnt <= sample_cnt + 1'b1;
					end
					if (var_ready) begin
						var_seen <= 1'b1;
					end
				end
				default: begin
					sample_cnt <= '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/sample_delay_line.sv
// Shift register delay line that replays each block's samples for the variance pass
`timescale 1ns/100ps
`default_nettype none

module sample_delay_line #(
	parameter int DEPTH = wiener_stats_pkg::BLOCK_SAMPLES
) (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        clr,
	input  wire                        shift_en,
	input  wire wiener_stats_pkg::sample_t data_in,
	output wiener_stats_pkg::sample_t  data_out
);
	import wiener_stats_pkg::*;

	sample_t stages [DEPTH];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				stages[i] <= '0;
			end
		end else if (clr) begin
			for (int i = 0; i < DEPTH; i++) begin
				stages[i] <= '0;
			end
		end else if (shift_en) begin
			stages[0] <= data_in;
			for (int i = 1; i < DEPTH; i++) begin
				stages[i] <= stages[i-1];
			end
		end
	end

	assign data_out = stages[DEPTH-1]; // Written DEPTH shifts ago

endmodule

`default_nettype wire

// File: rtl/block_mean.sv
// Block sample accumulator with floored mean output and ready pulse
`timescale 1ns/100ps
`default_nettype none

module block_mean (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        sample_take,
	input  wire wiener_stats_pkg::sample_t sample_in,
	output logic                       mean_ready,
	output wiener_stats_pkg::sample_t  mean_value
);
	import wiener_stats_pkg::*;

	localparam logic [BLOCK_LOG2-1:0] LAST_TAKE = BLOCK_LOG2'(BLOCK_SAMPLES - 1);

	logic [BLOCK_LOG2-1:0] take_cnt; // Wraps at the block boundary
	sum_t sum_q;
	sum_t sum_next;
	logic block_end;

	assign sum_next = sum_q + sum_t'(sample_in);
	assign block_end = sample_take && (take_cnt == LAST_TAKE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			take_cnt <= '0;
			sum_q <= '0;
			mean_ready <= 1'b0;
		end else begin
			mean_ready <= block_end;
			if (sample_take) begin
				take_cnt <= take_cnt + 1'b1;
				// Start the next block from zero
				sum_q <= block_end ? '0 : sum_next;
			end
		end
	end

	// Floor divide by the block size
	always_ff @(posedge clk) begin
		if (block_end) begin
			mean_value <= sample_t'(sum_next >> BLOCK_LOG2);
		end
	end

endmodule

`default_nettype wire

// File: rtl/block_variance.sv
// Squared deviation accumulator over delayed samples with floored variance output
`timescale 1ns/100ps
`default_nettype none

module block_variance (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        shift_en_mean,
	input  wire wiener_stats_pkg::sample_t mean_in,
	input  wire                        var_start,
	input  wire                        shift_en,
	input  wire wiener_stats_pkg::sample_t sample_in,
	output logic                       var_ready,
	output wiener_stats_pkg::var_t     var_value
);
	import wiener_stats_pkg::*;

	localparam logic [BLOCK_LOG2-1:0] LAST_SHIFT = BLOCK_LOG2'(BLOCK_SAMPLES - 1);

	sample_t mean_q;
	sample_t abs_dev;
	var_t sq_dev;
	var_t acc_q;
	var_t acc_next;
	logic active;
	logic [BLOCK_LOG2-1:0] shift_cnt;
	logic [BLOCK_LOG2-1:0] shift_idx;
	logic take_sample;
	logic last_shift;

	assign abs_dev = (sample_in >= mean_q) ? sample_in - mean_q : mean_q - sample_in;
	assign sq_dev = var_t'(abs_dev) * var_t'(abs_dev);

	// var_start shares its cycle with the first shift of the pass
	assign take_sample = shift_en && (var_start || active);
	assign shift_idx = var_start ? '0 : shift_cnt;
	assign last_shift = take_sample && (shift_idx == LAST_SHIFT);
	assign acc_next = var_start ? sq_dev : acc_q + sq_dev;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			shift_cnt <= '0;
			var_ready <= 1'b0;
		end else begin
			var_ready <= last_shift;
			if (take_sample) begin
				shift_cnt <= shift_idx + 1'b1;
				active <= !last_shift;
			end else if (var_start) begin
				shift_cnt <= '0;
				active <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (shift_en_mean) begin
			mean_q <= mean_in; // Held for the whole pass
		end
		if (take_sample) begin
			acc_q <= acc_next;
		end
		if (last_shift) begin
			var_value <= acc_next >> BLOCK_LOG2;
		end
	end

endmodule

`default_nettype wire

// File: rtl/noise_floor_tracker.sv
// Running minimum of block variances, published as the noise floor at frame end
`timescale 1ns/100ps
`default_nettype none

module noise_floor_tracker (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        var_ready,
	input  wire wiener_stats_pkg::var_t var_value,
	input  wire                        frame_done,
	output wiener_stats_pkg::var_t     noise_var,
	output logic                       noise_valid
);
	import wiener_stats_pkg::*;

	var_t min_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			min_q <= '1;
			noise_valid <= 1'b0;
		end else begin
			noise_valid <= frame_done;
			if (frame_done) begin
				min_q <= '1; // Fresh minimum for the next frame
			end else if (var_ready && (var_value < min_q)) begin
				min_q <= var_value;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (frame_done) begin
			noise_var <= min_q;
		end
	end

endmodule

`default_nettype wire

// File: rtl/wiener_stats_top.sv
// Top level wiring of block controller, delay line, mean, variance and noise floor units
`timescale 1ns/100ps
`default_nettype none

module wiener_stats_top (
	input  wire                                  clk,
	input  wire                                  rst_n,
	input  wire                                  start_of_frame,
	input  wire [wiener_stats_pkg::BLOCKS_W-1:0] blocks_per_frame,
	input  wire wiener_stats_pkg::sample_t       sample_in,
	output logic                                 sample_take,
	output wiener_stats_pkg::sample_t            mean_out,
	output logic                                 mean_valid,
	output wiener_stats_pkg::var_t               var_out,
	output logic                                 var_valid,
	output wiener_stats_pkg::var_t               noise_var,
	output logic                                 noise_valid,
	output logic                                 busy
);
	import wiener_stats_pkg::*;

	logic shift_en_2;
	logic shift_reg_clr;
	logic shift_en_mean;
	logic var_start;
	logic frame_done;
	sample_t delayed_sample;

	block_stats_ctrl ctrl0 (
		.clk              (clk),
		.rst_n            (rst_n),
		.start_of_frame   (start_of_frame),
		.blocks_per_frame (blocks_per_frame),
		.mean_ready       (mean_valid),
		.var_ready        (var_valid),
		.sample_take      (sample_take),
		.shift_en_2       (shift_en_2),
		.shift_reg_clr    (shift_reg_clr),
		.shift_en_mean    (shift_en_mean),
		.var_start        (var_start),
		.frame_done       (frame_done),
		.busy             (busy)
	);

	// Replays block k while block k+1 is read
	sample_delay_line #(.DEPTH(BLOCK_SAMPLES)) delay0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.clr      (shift_reg_clr),
		.shift_en (shift_en_2),
		.data_in  (sample_in),
		.data_out (delayed_sample)
	);

	block_mean mean0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.sample_take (sample_take),
		.sample_in   (sample_in),
		.mean_ready  (mean_valid),
		.mean_value  (mean_out)
	);

	block_variance var0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.shift_en_mean (shift_en_mean),
		.mean_in       (mean_out),
		.var_start     (var_start),
		.shift_en      (shift_en_2),
		.sample_in     (delayed_sample),
		.var_ready     (var_valid),
		.var_value     (var_out)
	);

	noise_floor_tracker noise0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.var_ready   (var_valid),
		.var_value   (var_out),
		.frame_done  (frame_done),
		.noise_var   (noise_var),
		.noise_valid (noise_valid)
	);

endmodule

`default_nettype wire

// File: tb/tb_wiener_stats.sv
// Directed testbench for wiener_stats_top with reference model, compare tasks and frame tests
`timescale 1ns/100ps
`default_nettype none

module tb_wiener_stats;
	import wiener_stats_pkg::*;

	localparam int MAX_BLOCKS = 4;
	localparam int MAX_SAMPLES = MAX_BLOCKS * BLOCK_SAMPLES;

	logic clk = 1'b0;
	logic rst_n;
	logic start_of_frame;
	logic [BLOCKS_W-1:0] blocks_per_frame;
	sample_t sample_in;
	logic sample_take;
	sample_t mean_out;
	logic mean_valid;
	var_t var_out;
	logic var_valid;
	var_t noise_var;
	logic noise_valid;
	logic busy;

	sample_t frame_data [MAX_SAMPLES];
	sample_t exp_mean [MAX_BLOCKS];
	var_t exp_var [MAX_BLOCKS];
	var_t exp_noise;

	// Written only by the falling edge monitor
	sample_t mean_got [$];
	var_t var_got [$];
	var_t noise_got [$];
	int take_cycles = 0;
	int active_cycles = 0;
	int var_at_noise = 0;
	logic take_seen = 1'b0;

	logic [31:0] rng_state = 32'hcda;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	wiener_stats_top dut0 (
		.clk              (clk),
		.rst_n            (rst_n),
		.start_of_frame   (start_of_frame),
		.blocks_per_frame (blocks_per_frame),
		.sample_in        (sample_in),
		.sample_take      (sample_take),
		.mean_out         (mean_out),
		.mean_valid       (mean_valid),
		.var_out          (var_out),
		.var_valid        (var_valid),
		.noise_var        (noise_var),
		.noise_valid      (noise_valid),
		.busy             (busy)
	);

	always #10 clk = ~clk; // 20 ns period

	// Outputs are stable mid-cycle
	always @(negedge clk) begin
		take_seen = sample_take;
		if (sample_take)
			take_cycles++;
		if (sample_take || busy || mean_valid || var_valid || noise_valid)
			active_cycles++;
		if (mean_valid)
			mean_got.push_back(mean_out);
		if (var_valid)
			var_got.push_back(var_out);
		if (noise_valid) begin
			noise_got.push_back(noise_var);
			var_at_noise = var_got.size(); // Variances seen before the noise floor
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic sample_t random_sample();
		rng_state = xorshift32(rng_state);
		return sample_t'(rng_state);
	endfunction

	task automatic check_sample(input string name, input sample_t got, input sample_t exp);
		if (got !== exp) begin
			errors++;
			$display("error at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_var(input string name, input var_t got, input var_t exp);
		if (got !== exp) begin
			errors++;
			$display("error at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			errors++;
			$display("error at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	// Sample = base plus masked random, mask 0 gives a constant block
	task automatic fill_block(input int b, input sample_t base, input sample_t mask);
		for (int i = 0; i < BLOCK_SAMPLES; i++)
			frame_data[b * BLOCK_SAMPLES + i] = base + (random_sample() & mask);
	endtask

	// Floored mean, variance about the floored mean, frame minimum
	task automatic build_reference(input int n_blocks);
		int sum;
		int dev_sum;
		int m;
		int d;
		exp_noise = '1;
		for (int b = 0; b < n_blocks; b++) begin
			sum = 0;
			for (int i = 0; i < BLOCK_SAMPLES; i++)
				sum += int'(frame_data[b * BLOCK_SAMPLES + i]);
			m = sum / BLOCK_SAMPLES;
			dev_sum = 0;
			for (int i = 0; i < BLOCK_SAMPLES; i++) begin
				d = int'(frame_data[b * BLOCK_SAMPLES + i]) - m;
				dev_sum += d * d;
			end
			exp_mean[b] = sample_t'(m);
			exp_var[b] = var_t'(dev_sum / BLOCK_SAMPLES);
			if (exp_var[b] < exp_noise)
				exp_noise = exp_var[b];
		end
	endtask

	// Starts a frame, feeds samples on sample_take and checks every result
	task automatic run_frame(input int n_blocks);
		int idx;
		int cycles;
		int limit;
		int mean_base;
		int var_base;
		int noise_base;
		int take_base;
		idx = 0;
		cycles = 0;
		limit = 40 * n_blocks + 100;
		build_reference(n_blocks);
		mean_base = mean_got.size();
		var_base = var_got.size();
		noise_base = noise_got.size();
		take_base = take_cycles;
		@(posedge clk);
		#2;
		blocks_per_frame = BLOCKS_W'(n_blocks);
		sample_in = frame_data[0];
		start_of_frame = 1'b1;
		@(posedge clk);
		#2;
		start_of_frame = 1'b0;
		check_flag("busy after start_of_frame", busy, 1'b1); // Frame has begun
		while (noise_got.size() == noise_base && cycles < limit) begin
			@(posedge clk);
			#2;
			if (take_seen && idx < MAX_SAMPLES - 1)
				idx++;
			sample_in = frame_data[idx];
			cycles++;
		end
		if (noise_got.size() == noise_base) begin
			errors++;
			$display("timeout: no noise_valid within %0d cycles of start_of_frame", limit);
		end
		repeat (4) @(posedge clk); // Catch any stray pulse
		#2;
		check_count("mean_valid pulses", mean_got.size() - mean_base, n_blocks);
		check_count("var_valid pulses", var_got.size() - var_base, n_blocks);
		check_count("noise_valid pulses", noise_got.size() - noise_base, 1);
		check_count("sample_take cycles", take_cycles - take_base, n_blocks * BLOCK_SAMPLES);
		check_count("var_valid before noise_valid", var_at_noise - var_base, n_blocks);
		for (int b = 0; b < n_blocks && mean_base + b < mean_got.size(); b++)
			check_sample("mean_out", mean_got[mean_base + b], exp_mean[b]);
		for (int b = 0; b < n_blocks && var_base + b < var_got.size(); b++)
			check_var("var_out", var_got[var_base + b], exp_var[b]);
		if (noise_got.size() > noise_base)
			check_var("noise_var", noise_got[noise_base], exp_noise);
		check_flag("busy", busy, 1'b0);
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: FAILED, %0d errors", tests_run, name, errors - errors_before);
		end
	endtask

	task automatic test_idle_after_reset();
		int errors_before;
		int active_base;
		errors_before = errors;
		active_base = active_cycles;
		repeat (10) @(posedge clk);
		#2;
		check_count("cycles with an output high while idle", active_cycles - active_base, 0);
		report_test("idle after reset", errors_before);
	endtask

	task automatic test_constant_block();
		int errors_before;
		errors_before = errors;
		fill_block(0, 8'h5a, 8'h00);
		run_frame(1);
		if (mean_got.size() > 0)
			check_sample("mean_out of constant block", mean_got[mean_got.size() - 1], 8'h5a);
		if (noise_got.size() > 0)
			check_var("noise_var of constant block", noise_got[noise_got.size() - 1], '0);
		report_test("one constant block", errors_before);
	endtask

	task automatic test_random_frame();
		int errors_before;
		errors_before = errors;
		for (int b = 0; b < 4; b++)
			fill_block(b, 8'h00, 8'hff);
		run_frame(4);
		report_test("four random blocks", errors_before);
	endtask

	task automatic test_quiet_middle_block();
		int errors_before;
		errors_before = errors;
		fill_block(0, 8'h00, 8'hff);
		fill_block(1, 8'd100, 8'h03); // Narrow spread
		fill_block(2, 8'h00, 8'hff);
		run_frame(3);
		if (noise_got.size() > 0)
			check_var("noise_var vs middle block", noise_got[noise_got.size() - 1], exp_var[1]);
		report_test("quiet middle block", errors_before);
	endtask

	task automatic test_back_to_back();
		int errors_before;
		errors_before = errors;
		fill_block(0, 8'h00, 8'hff);
		fill_block(1, 8'h00, 8'hff);
		fill_block(2, 8'd17, 8'h00); // Zero variance, sets a low minimum
		run_frame(3);
		fill_block(0, 8'h00, 8'hff);
		fill_block(1, 8'h00, 8'hff);
		run_frame(2);
		report_test("back to back frames", errors_before);
	endtask

	initial begin
		rst_n = 1'b0;
		start_of_frame = 1'b0;
		blocks_per_frame = '0;
		sample_in = '0;
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		test_idle_after_reset();
		test_constant_block();
		test_random_frame();
		test_quiet_middle_block();
		test_back_to_back();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
rtl/wiener_stats_pkg.sv
rtl/block_stats_ctrl.sv
rtl/sample_delay_line.sv
rtl/block_mean.sv
rtl/block_variance.sv
rtl/noise_floor_tracker.sv
rtl/wiener_stats_top.sv
tb/tb_wiener_stats.sv

// File: Makefile
VERILATOR  := verilator
FLAGS      := --binary --timing --timescale 1ns/100ps
LINT_FLAGS := --lint-only --timing --timescale 1ns/100ps
TOP        := tb_wiener_stats
RTL_TOP    := wiener_stats_top
FILELIST   := compile.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Some tests failed

SRCS := $(wildcard rtl/*.sv tb/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
